//--- design/dns_guard_pkg.sv
// shared widths, protocol constants and the receive beat view, imported by every guard module
`default_nettype none

package dns_guard_pkg;

	// stream geometry
	localparam int DATA_W = 64;
	localparam int KEEP_W = 8;

	// lookup interface to the hash table
	localparam int KEY_W  = 96;
	localparam int FLAG_W = 4;

	// beat index within a frame
	localparam int CNT_W = 10;

	localparam logic [15:0] ETH_FTYPE_IP  = 16'h0800;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
	localparam logic [15:0] DNS_SERV_PORT = 16'd53;

	// only this flag removes a frame, anything else lets it through
	localparam logic [FLAG_W-1:0] VERDICT_DROP = 4'b0001;

	// one receive word seen as bytes or as 16-bit lanes
	// byte 0 sits in bits 7:0, lane 0 in bits 15:0
	typedef union packed {
		logic [KEEP_W-1:0][7:0]    bytes;
		logic [DATA_W/16-1:0][15:0] halves;
	} rx_beat_t;

endpackage

`default_nettype wire

//--- design/frame_parser.sv
// receive-side header parser, detects DNS responses and issues one hash table lookup per frame
`timescale 1ns/1ps
`default_nettype none

module frame_parser (
	input  wire                             clk156,
	input  wire                             eth_rst,
	input  wire                             rx_tvalid,
	input  wire dns_guard_pkg::rx_beat_t    rx_tdata,
	input  wire                             rx_tlast,
	output logic [dns_guard_pkg::KEY_W-1:0] lookup_key,
	output logic                            lookup_valid,
	output logic                            frame_end,
	output logic                            frame_looked_up
);
	import dns_guard_pkg::*;

	logic [CNT_W-1:0] rx_cnt;
	logic [15:0]      ftype;
	logic [7:0]       ip_proto;
	logic [31:0]      src_ip;
	logic [31:0]      dst_ip;
	logic [15:0]      src_port;
	logic [15:0]      dst_port;
	logic             dns_resp;
	logic             issue;
	logic             lookup_done;

	// lanes hold the first wire byte low, fields want network order
	function automatic logic [15:0] swap16(input logic [15:0] lane);
		return {lane[7:0], lane[15:8]};
	endfunction

	// valid from beat 5 on, fields are cleared at beat 0
	assign dns_resp = ftype == ETH_FTYPE_IP && ip_proto == IP_PROTO_UDP &&
		src_port == DNS_SERV_PORT;
	assign issue = rx_tvalid && dns_resp && rx_cnt == CNT_W'(7);
	assign lookup_key = {src_ip, dst_ip, dst_port, 16'h0000};

	// header capture by beat index
	always_ff @(posedge clk156) begin
		if (rx_tvalid) begin
			case (rx_cnt)
				CNT_W'(0): begin
					ftype    <= '0;
					ip_proto <= '0;
					src_ip   <= '0;
					dst_ip   <= '0;
					src_port <= '0;
					dst_port <= '0;
				end
				CNT_W'(1): ftype <= swap16(rx_tdata.halves[2]);
				CNT_W'(2): ip_proto <= rx_tdata.bytes[7];
				CNT_W'(3): begin
					src_ip <= {rx_tdata.bytes[2], rx_tdata.bytes[3],
						rx_tdata.bytes[4], rx_tdata.bytes[5]};
					dst_ip[31:16] <= {rx_tdata.bytes[6], rx_tdata.bytes[7]};
				end
				CNT_W'(4): begin
					dst_ip[15:0] <= swap16(rx_tdata.halves[0]);
					src_port     <= swap16(rx_tdata.halves[1]);
					dst_port     <= swap16(rx_tdata.halves[2]);
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			rx_cnt          <= '0;
			lookup_valid    <= 1'b0;
			lookup_done     <= 1'b0;
			frame_end       <= 1'b0;
			frame_looked_up <= 1'b0;
		end else begin
			lookup_valid    <= issue;
			frame_end       <= rx_tvalid && rx_tlast;
			// an 8-beat frame issues on its own last beat
			frame_looked_up <= rx_tvalid && rx_tlast && (lookup_done || issue);
			if (rx_tvalid) begin
				if (rx_tlast) begin
					rx_cnt      <= '0;
					lookup_done <= 1'b0;
				end else begin
					// hold at the top so very long frames never reissue
					if (rx_cnt != '1)
						rx_cnt <= rx_cnt + 1'b1;
					if (issue)
						lookup_done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/beat_delay.sv
// fixed-length delay line for receive beats, covers the hash table lookup latency
`timescale 1ns/1ps
`default_nettype none

module beat_delay #(
	parameter int DELAY_STAGES = 12
) (
	input  wire                              clk156,
	input  wire                              eth_rst,
	input  wire                              in_valid,
	input  wire  [dns_guard_pkg::DATA_W-1:0] in_data,
	input  wire  [dns_guard_pkg::KEEP_W-1:0] in_keep,
	input  wire                              in_last,
	output logic                             dly_valid,
	output logic [dns_guard_pkg::DATA_W-1:0] dly_data,
	output logic [dns_guard_pkg::KEEP_W-1:0] dly_keep,
	output logic                             dly_last
);
	import dns_guard_pkg::*;

	logic [DELAY_STAGES-1:0] valid_sr;
	logic [DELAY_STAGES-1:0] last_sr;
	logic [DATA_W-1:0]       data_sr [DELAY_STAGES];
	logic [KEEP_W-1:0]       keep_sr [DELAY_STAGES];

	// stage 0 takes the input, last stage feeds the buffer
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			valid_sr <= '0;
			last_sr  <= '0;
			for (int i = 0; i < DELAY_STAGES; i++) begin
				data_sr[i] <= '0;
				keep_sr[i] <= '0;
			end
		end else begin
			valid_sr <= {valid_sr[DELAY_STAGES-2:0], in_valid};
			last_sr  <= {last_sr[DELAY_STAGES-2:0], in_last};
			data_sr[0] <= in_data;
			keep_sr[0] <= in_keep;
			for (int i = 1; i < DELAY_STAGES; i++) begin
				data_sr[i] <= data_sr[i-1];
				keep_sr[i] <= keep_sr[i-1];
			end
		end
	end

	assign dly_valid = valid_sr[DELAY_STAGES-1];
	assign dly_last  = last_sr[DELAY_STAGES-1];
	assign dly_data  = data_sr[DELAY_STAGES-1];
	assign dly_keep  = keep_sr[DELAY_STAGES-1];

endmodule

`default_nettype wire

//--- design/verdict_queue.sv
// per-frame decision queue, pairs in-order verdicts with frames and rules at each delayed frame end
`timescale 1ns/1ps
`default_nettype none

module verdict_queue #(
	parameter int QUEUE_ADDR_W = 4
) (
	input  wire                              clk156,
	input  wire                              eth_rst,
	input  wire                              frame_end,
	input  wire                              frame_looked_up,
	input  wire                              verdict_valid,
	input  wire  [dns_guard_pkg::FLAG_W-1:0] verdict_flag,
	input  wire                              dly_valid,
	input  wire                              dly_last,
	output logic                             frame_drop
);
	import dns_guard_pkg::*;

	localparam int DEPTH = 2**QUEUE_ADDR_W;

	logic [DEPTH-1:0]        q_looked;
	logic [DEPTH-1:0]        q_has_v;
	logic [DEPTH-1:0]        q_drop;
	logic [QUEUE_ADDR_W-1:0] wr_ptr;
	logic [QUEUE_ADDR_W-1:0] rd_ptr;
	logic [QUEUE_ADDR_W-1:0] tgt;
	logic [QUEUE_ADDR_W-1:0] idx;
	logic [QUEUE_ADDR_W:0]   count;
	logic [QUEUE_ADDR_W:0]   skip_cnt;
	logic found, v_live, v_drop, pop, expire, skip_dec;
	logic pend_valid, pend_drop;

	// oldest looked-up entry still waiting for its verdict
	always_comb begin
		found = 1'b0;
		tgt   = rd_ptr;
		idx   = rd_ptr;
		for (int i = 0; i < DEPTH; i++) begin
			idx = rd_ptr + QUEUE_ADDR_W'(i);
			if (!found && i < count && q_looked[idx] && !q_has_v[idx]) begin
				found = 1'b1;
				tgt   = idx;
			end
		end
	end

	// verdicts of frames that already left fail-open are swallowed first
	assign v_live   = verdict_valid && skip_cnt == '0;
	assign skip_dec = verdict_valid && skip_cnt != '0;
	assign v_drop   = verdict_flag == VERDICT_DROP;
	assign pop      = dly_valid && dly_last && count != '0;
	// a verdict on the pop cycle still counts for the head
	assign frame_drop = pop && (q_has_v[rd_ptr] ? q_drop[rd_ptr] :
		q_looked[rd_ptr] && v_live && v_drop);
	assign expire = pop && q_looked[rd_ptr] && !q_has_v[rd_ptr] && !v_live;

	always_ff @(posedge clk156) begin
		if (v_live && found) begin
			q_has_v[tgt] <= 1'b1;
			q_drop[tgt]  <= v_drop;
		end
		// verdict may beat the frame end, it waits in pend until the push
		if (frame_end) begin
			q_looked[wr_ptr] <= frame_looked_up;
			q_has_v[wr_ptr]  <= frame_looked_up && (pend_valid || (v_live && !found));
			q_drop[wr_ptr]   <= pend_valid ? pend_drop : v_drop;
		end
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			skip_cnt   <= '0;
			pend_valid <= 1'b0;
			pend_drop  <= 1'b0;
		end else begin
			if (frame_end) begin
				wr_ptr     <= wr_ptr + 1'b1;
				pend_valid <= 1'b0;
			end else if (v_live && !found) begin
				pend_valid <= 1'b1;
				pend_drop  <= v_drop;
			end
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (frame_end && !pop)
				count <= count + 1'b1;
			else if (!frame_end && pop)
				count <= count - 1'b1;
			if (expire && !skip_dec)
				skip_cnt <= skip_cnt + 1'b1;
			else if (!expire && skip_dec)
				skip_cnt <= skip_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/tx_frame_buffer.sv
// transmit frame store, commits or rewinds whole frames and drains them on a valid/ready stream
`timescale 1ns/1ps
`default_nettype none

module tx_frame_buffer #(
	parameter int BUF_ADDR_W = 6
) (
	input  wire                              clk156,
	input  wire                              eth_rst,
	input  wire                              wr_valid,
	input  wire  [dns_guard_pkg::DATA_W-1:0] wr_data,
	input  wire  [dns_guard_pkg::KEEP_W-1:0] wr_keep,
	input  wire                              wr_last,
	input  wire                              frame_drop,
	input  wire                              tx_tready,
	output logic                             tx_tvalid,
	output logic [dns_guard_pkg::DATA_W-1:0] tx_tdata,
	output logic [dns_guard_pkg::KEEP_W-1:0] tx_tkeep,
	output logic                             tx_tlast
);
	import dns_guard_pkg::*;

	localparam int DEPTH  = 2**BUF_ADDR_W;
	localparam int WORD_W = DATA_W + KEEP_W + 1;

	logic [WORD_W-1:0] mem [DEPTH];

	// one extra bit on each pointer tells full from empty
	logic [BUF_ADDR_W:0] wr_ptr;
	logic [BUF_ADDR_W:0] cmt_ptr;
	logic [BUF_ADDR_W:0] rd_ptr;
	logic ovf;
	logic full;
	logic wr_en;
	logic rewind;

	assign full = wr_ptr[BUF_ADDR_W] != rd_ptr[BUF_ADDR_W] &&
		wr_ptr[BUF_ADDR_W-1:0] == rd_ptr[BUF_ADDR_W-1:0];
	assign wr_en  = wr_valid && !full && !ovf;
	// a beat lost to a full store spoils the whole frame
	assign rewind = frame_drop || ovf || full;

	// reader only sees committed frames
	assign tx_tvalid = rd_ptr != cmt_ptr;
	assign {tx_tlast, tx_tkeep, tx_tdata} = mem[rd_ptr[BUF_ADDR_W-1:0]];

	always_ff @(posedge clk156) begin
		if (wr_en)
			mem[wr_ptr[BUF_ADDR_W-1:0]] <= {wr_last, wr_keep, wr_data};
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr  <= '0;
			cmt_ptr <= '0;
			rd_ptr  <= '0;
			ovf     <= 1'b0;
		end else begin
			if (tx_tvalid && tx_tready)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_valid) begin
				if (wr_last) begin
					ovf <= 1'b0;
					if (rewind) begin
						wr_ptr <= cmt_ptr;
					end else begin
						wr_ptr  <= wr_ptr + 1'b1;
						cmt_ptr <= wr_ptr + 1'b1;
					end
				end else if (full || ovf) begin
					// held until the frame's last beat
					ovf <= 1'b1;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/dns_guard_top.sv
// DNS response guard top level, joins parser, delay line, verdict queue and transmit buffer
`timescale 1ns/1ps
`default_nettype none

module dns_guard_top #(
	parameter int DELAY_STAGES = 12,
	parameter int BUF_ADDR_W   = 6,
	parameter int QUEUE_ADDR_W = 4
) (
	input  wire                              clk156,
	input  wire                              eth_rst,
	input  wire                              rx_tvalid,
	input  wire  [dns_guard_pkg::DATA_W-1:0] rx_tdata,
	input  wire  [dns_guard_pkg::KEEP_W-1:0] rx_tkeep,
	input  wire                              rx_tlast,
	output logic [dns_guard_pkg::KEY_W-1:0]  lookup_key,
	output logic                             lookup_valid,
	input  wire                              verdict_valid,
	input  wire  [dns_guard_pkg::FLAG_W-1:0] verdict_flag,
	output logic                             tx_tvalid,
	output logic [dns_guard_pkg::DATA_W-1:0] tx_tdata,
	output logic [dns_guard_pkg::KEEP_W-1:0] tx_tkeep,
	output logic                             tx_tlast,
	input  wire                              tx_tready
);
	import dns_guard_pkg::*;

	logic              frame_end, frame_looked_up;
	logic              dly_valid, dly_last;
	logic [DATA_W-1:0] dly_data;
	logic [KEEP_W-1:0] dly_keep;
	logic              frame_drop;

	// the parser sees the same word through the beat union
	frame_parser frame_parser_inst (
		.clk156, .eth_rst, .rx_tvalid,
		.rx_tdata (rx_tdata),
		.rx_tlast,
		.lookup_key, .lookup_valid, .frame_end, .frame_looked_up
	);

	beat_delay #(.DELAY_STAGES(DELAY_STAGES)) beat_delay_inst (
		.clk156, .eth_rst,
		.in_valid (rx_tvalid),
		.in_data  (rx_tdata),
		.in_keep  (rx_tkeep),
		.in_last  (rx_tlast),
		.dly_valid, .dly_data, .dly_keep, .dly_last
	);

	verdict_queue #(.QUEUE_ADDR_W(QUEUE_ADDR_W)) verdict_queue_inst (
		.clk156, .eth_rst, .frame_end, .frame_looked_up,
		.verdict_valid, .verdict_flag, .dly_valid, .dly_last, .frame_drop
	);

	tx_frame_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) tx_frame_buffer_inst (
		.clk156, .eth_rst,
		.wr_valid (dly_valid),
		.wr_data  (dly_data),
		.wr_keep  (dly_keep),
		.wr_last  (dly_last),
		.frame_drop, .tx_tready, .tx_tvalid, .tx_tdata, .tx_tkeep, .tx_tlast
	);

endmodule

`default_nettype wire

//--- test/tb_dns_guard.sv
// directed testbench for dns_guard_top, compiled from flist.f with tb_dns_guard as top
`timescale 1ns/1ps
`default_nettype none

module tb_dns_guard;
	import dns_guard_pkg::*;

	localparam int DELAY = 12;
	localparam int LATE  = 30;

	logic              clk156 = 1'b0;
	logic              eth_rst;
	logic              rx_tvalid;
	logic [DATA_W-1:0] rx_tdata;
	logic [KEEP_W-1:0] rx_tkeep;
	logic              rx_tlast;
	logic [KEY_W-1:0]  lookup_key;
	logic              lookup_valid;
	logic              verdict_valid;
	logic [FLAG_W-1:0] verdict_flag;
	logic              tx_tvalid;
	logic [DATA_W-1:0] tx_tdata;
	logic [KEEP_W-1:0] tx_tkeep;
	logic              tx_tlast;
	logic              tx_tready;

	// scoreboard
	logic [DATA_W-1:0] exp_data[$];
	logic [DATA_W-1:0] got_data[$];
	logic [KEEP_W-1:0] exp_keep[$];
	logic [KEEP_W-1:0] got_keep[$];
	logic              exp_last[$];
	logic              got_last[$];
	int exp_frames = 0;
	int got_frames = 0;
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	int cycle_limit = 20;

	// hash table model state
	logic             answer_on = 1'b0;
	int               answer_delay = 2;
	logic [FLAG_W-1:0] answer_flag = '0;
	int               answer_wait = 0;
	int               lookups = 0;
	int               lookup_lag = 0;
	int               b7_age = 0;
	int               rx_idx = 0;
	logic [KEY_W-1:0] seen_key = '0;

	// 0 ready, 1 random, 2 held low
	int          ready_mode = 0;
	logic [31:0] pay_seed = 32'h11a4;
	logic [31:0] rdy_seed = 32'h11a4;

	dns_guard_top #(
		.DELAY_STAGES(DELAY),
		.BUF_ADDR_W  (6),
		.QUEUE_ADDR_W(4)
	) dns_guard_top_inst (
		.clk156, .eth_rst, .rx_tvalid, .rx_tdata, .rx_tkeep, .rx_tlast,
		.lookup_key, .lookup_valid, .verdict_valid, .verdict_flag,
		.tx_tvalid, .tx_tdata, .tx_tkeep, .tx_tlast, .tx_tready
	);

	always #2 clk156 = ~clk156;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	always @(posedge clk156) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	// transmit side monitor
	always @(posedge clk156) begin
		if (!eth_rst && tx_tvalid && tx_tready) begin
			got_data.push_back(tx_tdata);
			got_keep.push_back(tx_tkeep);
			got_last.push_back(tx_tlast);
			if (tx_tlast)
				got_frames++;
		end
	end

	// hash table model, answers each lookup answer_delay cycles after the request
	always @(posedge clk156) begin
		logic fire;
		fire = 1'b0;
		if (answer_wait > 0) begin
			answer_wait--;
			fire = answer_wait == 0;
		end
		b7_age++;
		if (lookup_valid) begin
			lookups++;
			lookup_lag = b7_age;
			seen_key   = lookup_key;
			if (answer_on)
				answer_wait = answer_delay - 1;
		end
		if (rx_tvalid && !eth_rst) begin
			if (rx_idx == 7)
				b7_age = 0;
			rx_idx = rx_tlast ? 0 : rx_idx + 1;
		end
		#1;
		verdict_valid = fire;
		verdict_flag  = fire ? answer_flag : '0;
	end

	always @(posedge clk156) begin
		#1;
		if (ready_mode == 1) begin
			rdy_seed  = lcg_next(rdy_seed);
			tx_tready = rdy_seed[16];
		end else begin
			tx_tready = ready_mode == 0;
		end
	end

	task automatic count_check(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic key_check(input string name, input logic [KEY_W-1:0] exp, act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic beat_check(input string name, input logic [DATA_W-1:0] exp_d, act_d,
		input logic [KEEP_W-1:0] exp_k, act_k, input logic exp_l, act_l);
		checks++;
		if (exp_d !== act_d || exp_k !== act_k || exp_l !== act_l) begin
			errors++;
			$display("** Error %s: expected %h/%h/%b, actual %h/%h/%b",
				name, exp_d, exp_k, exp_l, act_d, act_k, act_l);
		end
	endtask

	// eth + ipv4 + udp header then LCG payload, packed first byte low
	task automatic send_frame(input logic [7:0] proto, input logic [31:0] src_ip, dst_ip,
		input logic [15:0] src_port, dst_port, input int pay_len, input bit passes);
		logic [42*8-1:0]   hdr;
		logic [7:0]        fb[$];
		logic [DATA_W-1:0] beat;
		logic [KEEP_W-1:0] keep;
		int                nbeats;
		hdr = {48'h020000000001, 48'h020000000002, ETH_FTYPE_IP, 8'h45, 8'h00,
			16'(28 + pay_len), 32'h0, 8'h40, proto, 16'h0, src_ip, dst_ip,
			src_port, dst_port, 16'(8 + pay_len), 16'h0};
		for (int k = 0; k < 42; k++)
			fb.push_back(hdr[(41-k)*8 +: 8]);
		for (int k = 0; k < pay_len; k++) begin
			pay_seed = lcg_next(pay_seed);
			fb.push_back(pay_seed[23:16]);
		end
		nbeats = (fb.size() + 7) / 8;
		// transmit may run at half rate, so each beat counts twice
		cycle_limit += 2 * nbeats;
		if (passes)
			exp_frames++;
		for (int b = 0; b < nbeats; b++) begin
			beat = '0;
			keep = '0;
			for (int j = 0; j < KEEP_W; j++) begin
				if (8*b + j < fb.size()) begin
					beat[8*j +: 8] = fb[8*b + j];
					keep[j] = 1'b1;
				end
			end
			@(posedge clk156);
			#1;
			rx_tvalid = 1'b1;
			rx_tdata  = beat;
			rx_tkeep  = keep;
			rx_tlast  = (b == nbeats - 1);
			if (passes) begin
				exp_data.push_back(beat);
				exp_keep.push_back(keep);
				exp_last.push_back(b == nbeats - 1);
			end
		end
	endtask

	// lets the delay line flush, empties the buffer and compares what came out
	task automatic drain_and_compare(input string name);
		int n;
		@(posedge clk156);
		#1;
		rx_tvalid = 1'b0;
		rx_tlast  = 1'b0;
		repeat (DELAY + 2) @(posedge clk156);
		#1;
		ready_mode = 0;
		while (tx_tvalid || answer_wait != 0) begin
			@(posedge clk156);
			#1;
		end
		count_check({name, " frames"}, exp_frames, got_frames);
		count_check({name, " beats"}, exp_data.size(), got_data.size());
		n = exp_data.size() < got_data.size() ? exp_data.size() : got_data.size();
		for (int i = 0; i < n; i++)
			beat_check(name, exp_data[i], got_data[i], exp_keep[i], got_keep[i],
				exp_last[i], got_last[i]);
		exp_data.delete();
		exp_keep.delete();
		exp_last.delete();
		got_data.delete();
		got_keep.delete();
		got_last.delete();
		exp_frames = 0;
		got_frames = 0;
	endtask

	task automatic non_dns_pass();
		cycle_limit += 40;
		lookups = 0;
		// icmp carries 53 where a udp source port would sit
		send_frame(8'h01, 32'h0a000001, 32'h0a000002, DNS_SERV_PORT, 16'd0, 30, 1'b1);
		send_frame(IP_PROTO_UDP, 32'h0a000003, 32'h0a000004, 16'd1234, 16'd53, 40, 1'b1);
		drain_and_compare("non_dns");
		count_check("non_dns lookups", 0, lookups);
	endtask

	task automatic lookup_key_timing();
		cycle_limit += 40;
		lookups     = 0;
		answer_on   = 1'b1;
		answer_delay = LATE;
		answer_flag = 4'b0000;
		send_frame(IP_PROTO_UDP, 32'hc0a80135, 32'h0a0000fe, DNS_SERV_PORT, 16'hc351, 30, 1'b1);
		drain_and_compare("lookup_key");
		count_check("lookup_key lookups", 1, lookups);
		count_check("lookup_key lag", 1, lookup_lag);
		key_check("lookup_key key", {32'hc0a80135, 32'h0a0000fe, 16'hc351, 16'h0000}, seen_key);
	endtask

	task automatic verdict_drop_pass();
		cycle_limit += 40;
		lookups      = 0;
		answer_on    = 1'b1;
		answer_delay = 2;
		answer_flag  = VERDICT_DROP;
		send_frame(IP_PROTO_UDP, 32'h0a000005, 32'h0a000006, 16'd5353, 16'd53, 22, 1'b1);
		send_frame(IP_PROTO_UDP, 32'h08080808, 32'h0a000007, DNS_SERV_PORT, 16'd4000, 30, 1'b0);
		send_frame(IP_PROTO_UDP, 32'h0a000008, 32'h0a000009, 16'd5353, 16'd53, 22, 1'b1);
		drain_and_compare("verdict_drop");
		answer_flag = 4'b0000;
		send_frame(IP_PROTO_UDP, 32'h08080404, 32'h0a00000a, DNS_SERV_PORT, 16'd4001, 30, 1'b1);
		drain_and_compare("verdict_pass");
		count_check("verdict lookups", 2, lookups);
	endtask

	task automatic fail_open_short();
		cycle_limit += 40;
		lookups      = 0;
		answer_on    = 1'b1;
		answer_delay = LATE;
		// drop flag arrives after the frame left, so it must not count
		answer_flag  = VERDICT_DROP;
		send_frame(IP_PROTO_UDP, 32'h01010101, 32'h0a00000b, DNS_SERV_PORT, 16'd4002, 40, 1'b1);
		send_frame(IP_PROTO_UDP, 32'h01000001, 32'h0a00000c, DNS_SERV_PORT, 16'd4003, 10, 1'b1);
		drain_and_compare("fail_open");
		count_check("fail_open lookups", 1, lookups);
	endtask

	task automatic back_pressure();
		cycle_limit += 40;
		answer_on  = 1'b0;
		ready_mode = 1;
		for (int i = 0; i < 4; i++)
			send_frame(IP_PROTO_UDP, 32'h0a000010 + i, 32'h0a000020, 16'd1234, 16'd80,
				38 + 8*i, 1'b1);
		drain_and_compare("ready_random");
		// 20-beat frames, the fourth one cannot fit in 64 entries
		ready_mode = 2;
		for (int i = 0; i < 4; i++)
			send_frame(IP_PROTO_UDP, 32'h0a000030 + i, 32'h0a000040, 16'd1234, 16'd80,
				118, i < 3);
		drain_and_compare("buffer_full");
	endtask

	initial begin
		eth_rst       = 1'b1;
		rx_tvalid     = 1'b0;
		rx_tdata      = '0;
		rx_tkeep      = '0;
		rx_tlast      = 1'b0;
		verdict_valid = 1'b0;
		verdict_flag  = '0;
		tx_tready     = 1'b1;
		repeat (10) @(posedge clk156);
		#1;
		eth_rst = 1'b0;
		non_dns_pass();
		lookup_key_timing();
		verdict_drop_pass();
		fail_open_short();
		back_pressure();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
design/dns_guard_pkg.sv
design/frame_parser.sv
design/beat_delay.sv
design/verdict_queue.sv
design/tx_frame_buffer.sv
design/dns_guard_top.sv
test/tb_dns_guard.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dns_guard
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx 'sim passed' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
